// File: rtl/cpu_pkg.sv
package cpu_pkg;

localparam int XLEN    = 32;
localparam int MD_ITER = 32;

typedef enum logic [5:0] {
	OP_NOP,
	OP_ADD,
	OP_ADDU,
	OP_SUB,
	OP_SUBU,
	OP_AND,
	OP_OR,
	OP_XOR,
	OP_NOR,
	OP_LUI,
	OP_SLT,
	OP_SLTU,
	OP_CLZ,
	OP_CLO,
	OP_SLL,
	OP_SRL,
	OP_SRA,
	OP_SLLV,
	OP_SRLV,
	OP_SRAV,
	OP_MULT,
	OP_MULTU,
	OP_DIV,
	OP_DIVU,
	OP_MFHI,
	OP_MFLO,
	OP_BEQ,
	OP_BNE,
	OP_BLEZ,
	OP_BGTZ,
	OP_BLTZ,
	OP_BGEZ,
	OP_J,
	OP_JAL,
	OP_JR,
	OP_INVALID
} oper_t;

typedef enum logic [1:0] { MD_MULT, MD_MULTU, MD_DIV, MD_DIVU } muldiv_op_t;

// matches the cp0 cause encoding
typedef enum logic [4:0] {
	EXC_NONE = 5'd0,
	EXC_RI   = 5'd10,
	EXC_OV   = 5'd12
} exc_code_t;

endpackage

// File: rtl/muldiv_if.sv
`timescale 1ns/100ps

interface muldiv_if;

// request side, stable while req is high
logic                       req;
cpu_pkg::muldiv_op_t        op;
logic [cpu_pkg::XLEN-1:0]   a;
logic [cpu_pkg::XLEN-1:0]   b;

// response side, hi and lo final once ack rises
logic                       ack;
logic [cpu_pkg::XLEN-1:0]   hi;
logic [cpu_pkg::XLEN-1:0]   lo;

modport master (
	output req, op, a, b,
	input  ack, hi, lo
);

modport slave (
	input  req, op, a, b,
	output ack, hi, lo
);

endinterface

// File: rtl/exec_alu.sv
`timescale 1ns/100ps

module exec_alu #(
	parameter int HAS_DIV = 1
) (
	input  cpu_pkg::oper_t             op,
	input  logic [cpu_pkg::XLEN-1:0]   reg1,
	input  logic [cpu_pkg::XLEN-1:0]   reg2,
	input  logic [15:0]                imm,
	input  logic [4:0]                 shamt,
	input  logic [cpu_pkg::XLEN-1:0]   pc,
	input  logic [cpu_pkg::XLEN-1:0]   hi,
	input  logic [cpu_pkg::XLEN-1:0]   lo,
	output logic [cpu_pkg::XLEN-1:0]   result,
	output cpu_pkg::exc_code_t         exc
);

localparam int XLEN  = cpu_pkg::XLEN;
localparam int CNT_W = $clog2(XLEN) + 1;

// priority scan from the msb
function automatic logic [CNT_W-1:0] lead_count(
	input logic [XLEN-1:0] val,
	input logic            bit_val
);
	logic [CNT_W-1:0] n;
	logic             stop;
	n    = '0;
	stop = 1'b0;
	for (int i = XLEN - 1; i >= 0; i--) begin
		if (!stop && val[i] == bit_val)
			n = n + 1'b1;
		else
			stop = 1'b1;
	end
	return n;
endfunction

logic [XLEN-1:0] add_u, sub_u;
assign add_u = reg1 + reg2;
assign sub_u = reg1 - reg2;

// signed overflow from the operand and result signs
logic ov_add, ov_sub;
assign ov_add = (reg1[XLEN-1] == reg2[XLEN-1]) & (reg1[XLEN-1] ^ add_u[XLEN-1]);
assign ov_sub = (reg1[XLEN-1] ^ reg2[XLEN-1]) & (reg1[XLEN-1] ^ sub_u[XLEN-1]);

logic signed_lt, unsigned_lt;
assign signed_lt   = (reg1[XLEN-1] != reg2[XLEN-1]) ? reg1[XLEN-1] : sub_u[XLEN-1];
assign unsigned_lt = (reg1 < reg2);

always_comb begin
	case (op)
		cpu_pkg::OP_ADD, cpu_pkg::OP_ADDU: result = add_u;
		cpu_pkg::OP_SUB, cpu_pkg::OP_SUBU: result = sub_u;
		cpu_pkg::OP_AND:  result = reg1 & reg2;
		cpu_pkg::OP_OR:   result = reg1 | reg2;
		cpu_pkg::OP_XOR:  result = reg1 ^ reg2;
		cpu_pkg::OP_NOR:  result = ~(reg1 | reg2);
		cpu_pkg::OP_LUI:  result = {imm, 16'b0};
		cpu_pkg::OP_SLT:  result = {{(XLEN-1){1'b0}}, signed_lt};
		cpu_pkg::OP_SLTU: result = {{(XLEN-1){1'b0}}, unsigned_lt};
		cpu_pkg::OP_CLZ:  result = XLEN'(lead_count(reg1, 1'b0));
		cpu_pkg::OP_CLO:  result = XLEN'(lead_count(reg1, 1'b1));
		cpu_pkg::OP_SLL:  result = reg2 << shamt;
		cpu_pkg::OP_SRL:  result = reg2 >> shamt;
		cpu_pkg::OP_SRA:  result = $signed(reg2) >>> shamt;
		cpu_pkg::OP_SLLV: result = reg2 << reg1[4:0];
		cpu_pkg::OP_SRLV: result = reg2 >> reg1[4:0];
		cpu_pkg::OP_SRAV: result = $signed(reg2) >>> reg1[4:0];
		cpu_pkg::OP_MFHI: result = hi;
		cpu_pkg::OP_MFLO: result = lo;
		// link past the delay slot
		cpu_pkg::OP_JAL:  result = pc + XLEN'(8);
		default:          result = '0;
	endcase
end

always_comb begin
	exc = cpu_pkg::EXC_NONE;
	if (op == cpu_pkg::OP_INVALID)
		exc = cpu_pkg::EXC_RI;
	else if (HAS_DIV == 0 && (op == cpu_pkg::OP_DIV || op == cpu_pkg::OP_DIVU))
		exc = cpu_pkg::EXC_RI;
	else if ((op == cpu_pkg::OP_ADD && ov_add) || (op == cpu_pkg::OP_SUB && ov_sub))
		exc = cpu_pkg::EXC_OV;
end

endmodule

// File: rtl/branch_resolve.sv
`timescale 1ns/100ps

module branch_resolve (
	input  cpu_pkg::oper_t             op,
	input  logic [cpu_pkg::XLEN-1:0]   reg1,
	input  logic [cpu_pkg::XLEN-1:0]   reg2,
	input  logic [15:0]                imm,
	input  logic [25:0]                target26,
	input  logic [cpu_pkg::XLEN-1:0]   pc,
	input  logic                       pred_valid,
	input  logic                       pred_taken,
	input  logic [cpu_pkg::XLEN-1:0]   pred_target,
	output logic                       taken,
	output logic [cpu_pkg::XLEN-1:0]   target,
	output logic                       mispredict,
	output logic                       is_cf
);

localparam int XLEN = cpu_pkg::XLEN;

logic [XLEN-1:0] pc_plus4, jump_i, jump_j;
logic            reg_equal;

assign pc_plus4  = pc + XLEN'(4);
assign jump_i    = pc_plus4 + {{(XLEN-18){imm[15]}}, imm, 2'b00};
assign jump_j    = {pc_plus4[XLEN-1:28], target26, 2'b00};
assign reg_equal = (reg1 == reg2);

always_comb begin
	taken      = 1'b0;
	target     = '0;
	mispredict = 1'b0;
	is_cf      = 1'b1;
	case (op)
		cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE, cpu_pkg::OP_BLEZ,
		cpu_pkg::OP_BGTZ, cpu_pkg::OP_BLTZ, cpu_pkg::OP_BGEZ: begin
			case (op)
				cpu_pkg::OP_BEQ:  taken = reg_equal;
				cpu_pkg::OP_BNE:  taken = ~reg_equal;
				cpu_pkg::OP_BLEZ: taken = reg1[XLEN-1] | (reg1 == '0);
				cpu_pkg::OP_BGTZ: taken = ~reg1[XLEN-1] & (reg1 != '0);
				cpu_pkg::OP_BLTZ: taken = reg1[XLEN-1];
				default:          taken = ~reg1[XLEN-1];
			endcase
			target     = jump_i;
			// direction wrong, or taken to the wrong place
			mispredict = pred_valid & (pred_taken ^ taken);
			if (taken)
				mispredict = mispredict | ~pred_valid | (pred_target != target);
		end
		cpu_pkg::OP_J, cpu_pkg::OP_JAL: begin
			taken      = 1'b1;
			target     = jump_j;
			mispredict = ~pred_valid | (pred_target != target);
		end
		cpu_pkg::OP_JR: begin
			taken      = 1'b1;
			target     = reg1;
			mispredict = ~pred_valid | (pred_target != target);
		end
		default: is_cf = 1'b0;
	endcase
end

endmodule

// File: rtl/muldiv_fsm.sv
`timescale 1ns/100ps

module muldiv_fsm #(
	parameter int HAS_DIV = 1
) (
	input  logic       clk,
	input  logic       rst,
	muldiv_if.slave    md,
	output logic       load,
	output logic       step,
	output logic       fixup,
	input  logic       zero
);

typedef enum logic [1:0] {
	S_IDLE,
	S_RUN,
	S_FIX,
	S_DONE
} state_t;

state_t state;
logic   start;
logic   is_div;

assign is_div = (md.op == cpu_pkg::MD_DIV) || (md.op == cpu_pkg::MD_DIVU);

// a disabled divide never starts the unit
assign start = md.req && (HAS_DIV != 0 || !is_div);

always_ff @(posedge clk) begin
	if (rst) begin
		state <= S_IDLE;
	end else begin
		case (state)
			S_IDLE: if (start) state <= S_RUN;
			// zero shows during the last step
			S_RUN:  if (zero) state <= S_FIX;
			S_FIX:  state <= S_DONE;
			S_DONE: if (!md.req) state <= S_IDLE;
			default: state <= S_IDLE;
		endcase
	end
end

assign load   = (state == S_IDLE) && start;
assign step   = (state == S_RUN);
assign fixup  = (state == S_FIX);
assign md.ack = (state == S_DONE);

ack_needs_req: assert property (@(posedge clk) disable iff (rst)
	$rose(md.ack) |-> md.req);

req_held_until_ack: assert property (@(posedge clk) disable iff (rst)
	$fell(md.req) |-> $past(md.ack));

// one step per iteration, then the sign fixup
run_length: assert property (@(posedge clk) disable iff (rst)
	load |=> step [*cpu_pkg::MD_ITER] ##1 fixup);

endmodule

// File: rtl/iter_counter.sv
`timescale 1ns/100ps

module iter_counter #(
	parameter int WIDTH = 6
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             load,
	input  logic             step,
	input  logic [WIDTH-1:0] init,
	output logic             zero
);

logic [WIDTH-1:0] count;

always_ff @(posedge clk) begin
	if (rst)
		count <= '0;
	else if (load)
		count <= init;
	else if (step)
		count <= count - 1'b1;
end

assign zero = (count == '0);

// the count must never wrap
no_step_at_zero: assert property (@(posedge clk) disable iff (rst)
	step |-> !zero);

endmodule

// File: rtl/muldiv_datapath.sv
`timescale 1ns/100ps

module muldiv_datapath (
	input  logic       clk,
	input  logic       rst,
	muldiv_if.slave    md,
	input  logic       load,
	input  logic       step,
	input  logic       fixup
);

localparam int XLEN = cpu_pkg::XLEN;

// acc is the high half or remainder, mq the multiplier or quotient
logic [XLEN-1:0]   acc, mq, opb;
logic              neg_res, neg_rem;
logic              is_signed, is_div;
logic [XLEN-1:0]   abs_a, abs_b;
logic [XLEN:0]     mul_sum;
logic [XLEN:0]     div_shift;
logic [XLEN+1:0]   div_diff;
logic [2*XLEN-1:0] prod_neg;

assign is_signed = (md.op == cpu_pkg::MD_MULT) || (md.op == cpu_pkg::MD_DIV);
assign is_div    = (md.op == cpu_pkg::MD_DIV) || (md.op == cpu_pkg::MD_DIVU);
assign abs_a     = (is_signed && md.a[XLEN-1]) ? -md.a : md.a;
assign abs_b     = (is_signed && md.b[XLEN-1]) ? -md.b : md.b;

assign mul_sum   = {1'b0, acc} + (mq[0] ? {1'b0, opb} : '0);
assign div_shift = {acc, mq[XLEN-1]};
assign div_diff  = {1'b0, div_shift} - {2'b00, opb};
assign prod_neg  = -{acc, mq};

always_ff @(posedge clk) begin
	if (rst) begin
		neg_res <= 1'b0;
		neg_rem <= 1'b0;
	end else if (load) begin
		neg_res <= is_signed && (md.a[XLEN-1] ^ md.b[XLEN-1]);
		neg_rem <= is_signed && md.a[XLEN-1];
	end
end

always_ff @(posedge clk) begin
	if (load) begin
		acc <= '0;
		mq  <= abs_a;
		opb <= abs_b;
	end else if (step) begin
		if (is_div) begin
			// restore when the trial subtract goes negative
			if (div_diff[XLEN+1]) begin
				acc <= div_shift[XLEN-1:0];
				mq  <= {mq[XLEN-2:0], 1'b0};
			end else begin
				acc <= div_diff[XLEN-1:0];
				mq  <= {mq[XLEN-2:0], 1'b1};
			end
		end else begin
			acc <= mul_sum[XLEN:1];
			mq  <= {mul_sum[0], mq[XLEN-1:1]};
		end
	end else if (fixup) begin
		if (is_div) begin
			if (neg_res)
				mq <= -mq;
			if (neg_rem)
				acc <= -acc;
		end else if (neg_res) begin
			{acc, mq} <= prod_neg;
		end
	end
end

assign md.hi = acc;
assign md.lo = mq;

endmodule

// File: rtl/exec_stage.sv
`timescale 1ns/100ps

module exec_stage #(
	parameter int HAS_DIV = 1
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       flush,
	input  logic                       in_valid,
	input  cpu_pkg::oper_t             op,
	input  logic [cpu_pkg::XLEN-1:0]   reg1,
	input  logic [cpu_pkg::XLEN-1:0]   reg2,
	input  logic [31:0]                instr,
	input  logic [cpu_pkg::XLEN-1:0]   pc,
	input  logic                       pred_valid,
	input  logic                       pred_taken,
	input  logic [cpu_pkg::XLEN-1:0]   pred_target,
	output logic                       out_valid,
	output logic [cpu_pkg::XLEN-1:0]   result,
	output cpu_pkg::exc_code_t         exc_code,
	output logic                       br_valid,
	output logic                       br_taken,
	output logic [cpu_pkg::XLEN-1:0]   br_target,
	output logic                       br_mispredict,
	output logic [cpu_pkg::XLEN-1:0]   hi,
	output logic [cpu_pkg::XLEN-1:0]   lo,
	output logic                       stall
);

localparam int XLEN   = cpu_pkg::XLEN;
localparam int ITER_W = $clog2(cpu_pkg::MD_ITER + 1);

logic [XLEN-1:0]     alu_result, cf_target;
cpu_pkg::exc_code_t  alu_exc;
logic                cf_taken, cf_mispredict, is_cf;
logic                accept, is_md, md_start;
cpu_pkg::muldiv_op_t md_op;
logic                md_load, md_step, md_fixup, iter_zero;

muldiv_if md_bus ();

exec_alu #(
	.HAS_DIV(HAS_DIV)
) exec_alu_inst (
	.op(op), .reg1(reg1), .reg2(reg2), .imm(instr[15:0]), .shamt(instr[10:6]),
	.pc(pc), .hi(hi), .lo(lo), .result(alu_result), .exc(alu_exc)
);

branch_resolve branch_resolve_inst (
	.op(op), .reg1(reg1), .reg2(reg2), .imm(instr[15:0]), .target26(instr[25:0]),
	.pc(pc), .pred_valid(pred_valid), .pred_taken(pred_taken),
	.pred_target(pred_target), .taken(cf_taken), .target(cf_target),
	.mispredict(cf_mispredict), .is_cf(is_cf)
);

muldiv_fsm #(
	.HAS_DIV(HAS_DIV)
) muldiv_fsm_inst (
	.clk(clk), .rst(rst), .md(md_bus), .load(md_load), .step(md_step),
	.fixup(md_fixup), .zero(iter_zero)
);

// the last step finds the count already at zero
iter_counter #(
	.WIDTH(ITER_W)
) iter_counter_inst (
	.clk(clk), .rst(rst), .load(md_load), .step(md_step & ~iter_zero),
	.init(ITER_W'(cpu_pkg::MD_ITER - 1)), .zero(iter_zero)
);

muldiv_datapath muldiv_datapath_inst (
	.clk(clk), .rst(rst), .md(md_bus), .load(md_load), .step(md_step), .fixup(md_fixup)
);

always_comb begin
	is_md = 1'b1;
	md_op = cpu_pkg::MD_MULT;
	case (op)
		cpu_pkg::OP_MULT:  md_op = cpu_pkg::MD_MULT;
		cpu_pkg::OP_MULTU: md_op = cpu_pkg::MD_MULTU;
		cpu_pkg::OP_DIV:   md_op = cpu_pkg::MD_DIV;
		cpu_pkg::OP_DIVU:  md_op = cpu_pkg::MD_DIVU;
		default:           is_md = 1'b0;
	endcase
end

// ack stays up one cycle after req drops, keep holding until then
assign stall    = md_bus.req | md_bus.ack;
assign accept   = in_valid && !stall;
assign md_start = accept && is_md && (alu_exc == cpu_pkg::EXC_NONE);

always_ff @(posedge clk) begin
	if (rst) begin
		out_valid     <= 1'b0;
		br_valid      <= 1'b0;
		br_mispredict <= 1'b0;
	end else begin
		out_valid     <= accept && !md_start && !flush;
		br_valid      <= accept && is_cf && !flush;
		br_mispredict <= accept && is_cf && cf_mispredict && !flush;
	end
end

always_ff @(posedge clk) begin
	if (accept) begin
		result    <= alu_result;
		exc_code  <= alu_exc;
		br_taken  <= cf_taken;
		br_target <= cf_target;
	end
	if (md_start) begin
		md_bus.op <= md_op;
		md_bus.a  <= reg1;
		md_bus.b  <= reg2;
	end
end

// handshake master, hi and lo taken with ack
always_ff @(posedge clk) begin
	if (rst) begin
		md_bus.req <= 1'b0;
		hi         <= '0;
		lo         <= '0;
	end else if (md_start) begin
		md_bus.req <= 1'b1;
	end else if (md_bus.req && md_bus.ack) begin
		md_bus.req <= 1'b0;
		hi         <= md_bus.hi;
		lo         <= md_bus.lo;
	end
end

endmodule

// File: verif/exec_stage_tb.sv
`timescale 1ns/100ps

module exec_stage_tb;

localparam int CLK_PERIOD   = 8;
localparam int RESET_CYCLES = 8;
localparam int N_ALU        = 200;
localparam int N_DIRECTED   = 21;
localparam int N_BR         = 120;
localparam int N_MD         = 48;
localparam int N_FLUSH      = 8;
// each multiply/divide is followed by MFHI and MFLO
localparam int TOTAL_OPS    = N_ALU + N_DIRECTED + N_BR + 3 * N_MD + N_FLUSH;

logic clk = 1'b0;
logic rst, flush, in_valid, pred_valid, pred_taken;
cpu_pkg::oper_t op;
logic [31:0] reg1, reg2, instr, pc, pred_target;
logic out_valid, br_valid, br_taken, br_mispredict, stall;
logic [31:0] result, br_target, hi, lo;
cpu_pkg::exc_code_t exc_code;

string              test_name;
logic [31:0]        exp_result, exp_target, model_hi, model_lo;
cpu_pkg::exc_code_t exp_exc;
logic [2:0]         exp_flags;
logic               exp_cf;
logic               is_md_op, acc_md, acc_single;

cpu_pkg::oper_t alu_ops [19] = '{
	cpu_pkg::OP_ADD, cpu_pkg::OP_ADDU, cpu_pkg::OP_SUB, cpu_pkg::OP_SUBU,
	cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_NOR,
	cpu_pkg::OP_LUI, cpu_pkg::OP_SLT, cpu_pkg::OP_SLTU, cpu_pkg::OP_CLZ,
	cpu_pkg::OP_CLO, cpu_pkg::OP_SLL, cpu_pkg::OP_SRL, cpu_pkg::OP_SRA,
	cpu_pkg::OP_SLLV, cpu_pkg::OP_SRLV, cpu_pkg::OP_SRAV
};
cpu_pkg::oper_t cf_ops [9] = '{
	cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE, cpu_pkg::OP_BLEZ, cpu_pkg::OP_BGTZ,
	cpu_pkg::OP_BLTZ, cpu_pkg::OP_BGEZ, cpu_pkg::OP_J, cpu_pkg::OP_JAL, cpu_pkg::OP_JR
};
cpu_pkg::oper_t md_ops [4] = '{
	cpu_pkg::OP_MULT, cpu_pkg::OP_MULTU, cpu_pkg::OP_DIV, cpu_pkg::OP_DIVU
};
cpu_pkg::oper_t ovf_ops [4] = '{
	cpu_pkg::OP_ADD, cpu_pkg::OP_ADDU, cpu_pkg::OP_SUB, cpu_pkg::OP_SUBU
};
logic [31:0] ovf_a [4] = '{32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff};
logic [31:0] ovf_b [4] = '{32'h0000_0001, 32'h0000_0001, 32'h8000_0000, 32'hffff_ffff};

exec_stage #(
	.HAS_DIV(1)
) exec_stage_inst (.*);

always #(CLK_PERIOD / 2) clk = ~clk;

function automatic logic is_muldiv(input cpu_pkg::oper_t o);
	return o == cpu_pkg::OP_MULT || o == cpu_pkg::OP_MULTU ||
		o == cpu_pkg::OP_DIV || o == cpu_pkg::OP_DIVU;
endfunction

function automatic logic is_jump(input cpu_pkg::oper_t o);
	return o == cpu_pkg::OP_J || o == cpu_pkg::OP_JAL || o == cpu_pkg::OP_JR;
endfunction

function automatic int lead_bits(input logic [31:0] v, input logic b);
	int n;
	n = 0;
	while (n < 32 && v[31 - n] == b)
		n++;
	return n;
endfunction

function automatic logic [31:0] model_result(input cpu_pkg::oper_t o,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] ins,
		input logic [31:0] p);
	logic [4:0] sh;
	sh = ins[10:6];
	case (o)
		cpu_pkg::OP_ADD, cpu_pkg::OP_ADDU: return a + b;
		cpu_pkg::OP_SUB, cpu_pkg::OP_SUBU: return a - b;
		cpu_pkg::OP_AND:  return a & b;
		cpu_pkg::OP_OR:   return a | b;
		cpu_pkg::OP_XOR:  return a ^ b;
		cpu_pkg::OP_NOR:  return ~(a | b);
		cpu_pkg::OP_LUI:  return {ins[15:0], 16'h0};
		cpu_pkg::OP_SLT:  return {31'b0, $signed(a) < $signed(b)};
		cpu_pkg::OP_SLTU: return {31'b0, a < b};
		cpu_pkg::OP_CLZ:  return 32'(lead_bits(a, 1'b0));
		cpu_pkg::OP_CLO:  return 32'(lead_bits(a, 1'b1));
		cpu_pkg::OP_SLL:  return b << sh;
		cpu_pkg::OP_SRL:  return b >> sh;
		cpu_pkg::OP_SRA:  return $signed(b) >>> sh;
		cpu_pkg::OP_SLLV: return b << a[4:0];
		cpu_pkg::OP_SRLV: return b >> a[4:0];
		cpu_pkg::OP_SRAV: return $signed(b) >>> a[4:0];
		cpu_pkg::OP_MFHI: return model_hi;
		cpu_pkg::OP_MFLO: return model_lo;
		cpu_pkg::OP_JAL:  return p + 32'd8;
		default:          return 32'h0;
	endcase
endfunction

function automatic cpu_pkg::exc_code_t model_exc(input cpu_pkg::oper_t o,
		input logic [31:0] a, input logic [31:0] b);
	longint sum;
	sum = 0;
	if (o == cpu_pkg::OP_INVALID)
		return cpu_pkg::EXC_RI;
	if (o == cpu_pkg::OP_ADD)
		sum = longint'($signed(a)) + longint'($signed(b));
	else if (o == cpu_pkg::OP_SUB)
		sum = longint'($signed(a)) - longint'($signed(b));
	// true sum must fit in 32 signed bits
	if (sum != longint'($signed(sum[31:0])))
		return cpu_pkg::EXC_OV;
	return cpu_pkg::EXC_NONE;
endfunction

function automatic void model_branch(input cpu_pkg::oper_t o, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] ins, input logic [31:0] p,
		input logic pv, input logic pt, input logic [31:0] ptg,
		output logic cf, output logic tk, output logic [31:0] tg, output logic mp);
	logic [31:0] next_pc;
	next_pc = p + 32'd4;
	cf = 1'b1;
	tk = 1'b0;
	tg = 32'h0;
	mp = 1'b0;
	case (o)
		cpu_pkg::OP_BEQ:  tk = (a == b);
		cpu_pkg::OP_BNE:  tk = (a != b);
		cpu_pkg::OP_BLEZ: tk = ($signed(a) <= 0);
		cpu_pkg::OP_BGTZ: tk = ($signed(a) > 0);
		cpu_pkg::OP_BLTZ: tk = ($signed(a) < 0);
		cpu_pkg::OP_BGEZ: tk = ($signed(a) >= 0);
		cpu_pkg::OP_J, cpu_pkg::OP_JAL, cpu_pkg::OP_JR: tk = 1'b1;
		default: cf = 1'b0;
	endcase
	if (cf) begin
		if (o == cpu_pkg::OP_JR)
			tg = a;
		else if (is_jump(o))
			tg = {next_pc[31:28], ins[25:0], 2'b00};
		else
			tg = next_pc + {{14{ins[15]}}, ins[15:0], 2'b00};
		if (tk && !pv)
			mp = 1'b1;
		else if (pv && !is_jump(o) && pt != tk)
			mp = 1'b1;
		else if (tk && ptg != tg)
			mp = 1'b1;
	end
endfunction

// returns {hi, lo}
function automatic logic [63:0] model_muldiv(input cpu_pkg::oper_t o,
		input logic [31:0] a, input logic [31:0] b);
	longint sa, sb;
	sa = longint'($signed(a));
	sb = longint'($signed(b));
	case (o)
		cpu_pkg::OP_MULT:  return sa * sb;
		cpu_pkg::OP_MULTU: return {32'h0, a} * {32'h0, b};
		cpu_pkg::OP_DIV: begin
			// zero divisor leaves the dividend as remainder and all ones before the sign
			if (b == 32'h0)
				return {a, a[31] ? 32'h1 : 32'hffff_ffff};
			return {32'(sa % sb), 32'(sa / sb)};
		end
		default: begin
			if (b == 32'h0)
				return {a, 32'hffff_ffff};
			return {a % b, a / b};
		end
	endcase
endfunction

function automatic logic [31:0] pick_operand();
	case ($urandom_range(0, 7))
		0: return 32'h0000_0000;
		1: return 32'hffff_ffff;
		2: return 32'h8000_0000;
		3: return 32'h7fff_ffff;
		4: return 32'h0000_0001;
		default: return $urandom;
	endcase
endfunction

task automatic fail_run(input string why);
	$display("%s", why);
	$display("Something failed");
	$fatal(1, "run stopped");
endtask

task automatic report_mismatch(input string what, input logic [31:0] exp_val,
		input logic [31:0] act_val);
	fail_run($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp_val, act_val));
endtask

// enters and leaves on a falling edge with stall low
task automatic issue_op(input string name, input cpu_pkg::oper_t o, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] ins, input logic [31:0] p,
		input logic pv, input logic pt, input logic [31:0] ptg, input logic fl);
	logic [63:0] hilo;
	logic        cf, tk, mp;
	logic [31:0] tg;
	test_name   = name;
	op          = o;
	reg1        = a;
	reg2        = b;
	instr       = ins;
	pc          = p;
	pred_valid  = pv;
	pred_taken  = pt;
	pred_target = ptg;
	flush       = fl;
	in_valid    = 1'b1;
	if (is_muldiv(o)) begin
		hilo     = model_muldiv(o, a, b);
		model_hi = hilo[63:32];
		model_lo = hilo[31:0];
		@(negedge clk);
		while (stall)
			@(negedge clk);
		in_valid = 1'b0;
		@(negedge clk);
	end else begin
		model_branch(o, a, b, ins, p, pv, pt, ptg, cf, tk, tg, mp);
		exp_result = model_result(o, a, b, ins, p);
		exp_exc    = model_exc(o, a, b);
		exp_cf     = cf;
		exp_target = tg;
		exp_flags  = {cf, tk, mp};
		@(negedge clk);
		in_valid = 1'b0;
		flush    = 1'b0;
		@(negedge clk);
	end
endtask

assign is_md_op   = is_muldiv(op);
assign acc_md     = in_valid && !stall && is_md_op;
assign acc_single = in_valid && !stall && !is_md_op;

out_valid_shown: assert property (@(posedge clk) disable iff (rst)
	acc_single && !flush |=> out_valid)
	else fail_run($sformatf("%s: out_valid missing after an accepted op", test_name));

flush_hides: assert property (@(posedge clk) disable iff (rst)
	acc_single && flush |=> !out_valid && !br_valid && !br_mispredict)
	else fail_run("a valid or mispredict flag set after a flushed op");

result_ok: assert property (@(posedge clk) disable iff (rst)
	acc_single && !flush |=> result == exp_result)
	else report_mismatch("result", exp_result, $sampled(result));

exc_ok: assert property (@(posedge clk) disable iff (rst)
	acc_single && !flush |=> exc_code == exp_exc)
	else report_mismatch("exc_code", 32'(exp_exc), 32'($sampled(exc_code)));

br_flags_ok: assert property (@(posedge clk) disable iff (rst)
	acc_single && !flush |=> {br_valid, br_taken, br_mispredict} == exp_flags)
	else report_mismatch("br_valid/taken/mispredict", 32'(exp_flags),
		32'({$sampled(br_valid), $sampled(br_taken), $sampled(br_mispredict)}));

br_target_ok: assert property (@(posedge clk) disable iff (rst)
	acc_single && !flush && exp_cf |=> br_target == exp_target)
	else report_mismatch("br_target", exp_target, $sampled(br_target));

stall_rises: assert property (@(posedge clk) disable iff (rst)
	acc_md |=> stall)
	else fail_run("stall did not rise after a multiply/divide was accepted");

quiet_while_stalled: assert property (@(posedge clk) disable iff (rst)
	stall |-> !out_valid)
	else fail_run("out_valid set while the stage was stalled");

hi_ok: assert property (@(posedge clk) disable iff (rst)
	$fell(stall) |-> hi == model_hi)
	else report_mismatch("hi", model_hi, $sampled(hi));

lo_ok: assert property (@(posedge clk) disable iff (rst)
	$fell(stall) |-> lo == model_lo)
	else report_mismatch("lo", model_lo, $sampled(lo));

reset_clean: assert property (@(posedge clk)
	$fell(rst) |-> !out_valid && !stall && !br_valid && !br_mispredict &&
		hi == 32'h0 && lo == 32'h0)
	else fail_run("outputs not cleared by reset");

initial begin : watchdog
	#(CLK_PERIOD * (TOTAL_OPS * 40 + RESET_CYCLES + 100));
	fail_run("watchdog expired before all operations completed");
end

initial begin : stimulus
	cpu_pkg::oper_t o;
	logic [31:0]    a, b, ins, p, ptg, tg;
	logic           pv, pt, cf, tk, mp;
	void'($urandom(32'h4b46_d880));
	rst         = 1'b1;
	flush       = 1'b0;
	in_valid    = 1'b0;
	op          = cpu_pkg::OP_NOP;
	reg1        = 32'h0;
	reg2        = 32'h0;
	instr       = 32'h0;
	pc          = 32'h0;
	pred_valid  = 1'b0;
	pred_taken  = 1'b0;
	pred_target = 32'h0;
	test_name   = "reset";
	exp_result  = 32'h0;
	exp_exc     = cpu_pkg::EXC_NONE;
	exp_flags   = 3'b000;
	exp_cf      = 1'b0;
	exp_target  = 32'h0;
	model_hi    = 32'h0;
	model_lo    = 32'h0;
	repeat (RESET_CYCLES) @(negedge clk);
	rst = 1'b0;
	@(negedge clk);

	for (int i = 0; i < N_ALU; i++) begin
		o = alu_ops[$urandom_range(0, 18)];
		issue_op($sformatf("alu %s", o.name()), o, pick_operand(), pick_operand(), $urandom,
			$urandom & ~32'h3, 1'b0, 1'b0, 32'h0, 1'b0);
	end

	// leading-bit count on the extremes
	for (int i = 0; i < 4; i++) begin
		o = (i < 2) ? cpu_pkg::OP_CLZ : cpu_pkg::OP_CLO;
		a = (i % 2 == 0) ? 32'h0 : 32'hffff_ffff;
		issue_op($sformatf("count %s", o.name()), o, a, 32'h0, 32'h0, 32'h0,
			1'b0, 1'b0, 32'h0, 1'b0);
	end
	for (int i = 0; i < 16; i++) begin
		o = ovf_ops[i % 4];
		issue_op($sformatf("overflow %s", o.name()), o, ovf_a[i / 4], ovf_b[i / 4],
			32'h0, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0);
	end
	issue_op("invalid op", cpu_pkg::OP_INVALID, $urandom, $urandom, $urandom, 32'h0,
		1'b0, 1'b0, 32'h0, 1'b0);

	for (int i = 0; i < N_BR; i++) begin
		o   = cf_ops[$urandom_range(0, 8)];
		a   = pick_operand();
		b   = ($urandom_range(0, 1) == 0) ? a : pick_operand();
		ins = $urandom;
		p   = $urandom & ~32'h3;
		pv  = ($urandom_range(0, 1) == 1);
		// jumps are only ever predicted taken
		pt  = is_jump(o) ? pv : ($urandom_range(0, 1) == 1);
		model_branch(o, a, b, ins, p, 1'b0, 1'b0, 32'h0, cf, tk, tg, mp);
		ptg = ($urandom_range(0, 3) != 0) ? tg : ($urandom & ~32'h3);
		issue_op($sformatf("branch %s", o.name()), o, a, b, ins, p, pv, pt, ptg, 1'b0);
	end

	for (int i = 0; i < N_MD; i++) begin
		o = md_ops[i % 4];
		a = (i >= 4 && i < 8) ? 32'h8000_0000 : pick_operand();
		b = (i < 4) ? 32'h0 : ((i < 8) ? 32'hffff_ffff : pick_operand());
		issue_op($sformatf("muldiv %s", o.name()), o, a, b, 32'h0, 32'h0,
			1'b0, 1'b0, 32'h0, 1'b0);
		issue_op("read hi", cpu_pkg::OP_MFHI, 32'h0, 32'h0, 32'h0, 32'h0,
			1'b0, 1'b0, 32'h0, 1'b0);
		issue_op("read lo", cpu_pkg::OP_MFLO, 32'h0, 32'h0, 32'h0, 32'h0,
			1'b0, 1'b0, 32'h0, 1'b0);
	end

	// flushed alu ops and flushed control flow alternate
	for (int i = 0; i < N_FLUSH; i++) begin
		if (i % 2 == 0)
			o = alu_ops[$urandom_range(0, 18)];
		else
			o = cf_ops[$urandom_range(0, 8)];
		issue_op($sformatf("flush %s", o.name()), o, pick_operand(), pick_operand(),
			$urandom, 32'h0, 1'b0, 1'b0, 32'h0, 1'b1);
	end

	$display("Everything OK");
	$finish;
end

endmodule

// File: all.f
rtl/cpu_pkg.sv
rtl/muldiv_if.sv
rtl/exec_alu.sv
rtl/branch_resolve.sv
rtl/muldiv_fsm.sv
rtl/iter_counter.sv
rtl/muldiv_datapath.sv
rtl/exec_stage.sv
verif/exec_stage_tb.sv

// File: run.sh
#!/bin/sh
# build the exec stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module exec_stage_tb -f all.f -o exec_stage_sim || exit 1

out=$(./obj_dir/exec_stage_sim 2>&1)
echo "$out"

echo "$out" | grep -q "Everything OK" && echo "PASS" || { echo "FAIL"; exit 1; }
